// ==== common/eth_pkg.sv ====
// untagged Ethernet II header only; payload is one byte per beat, counters wrap at 2**stat_width
package eth_pkg;

    // address and type fields in wire order
    typedef logic [47:0] mac_t;
    typedef logic [15:0] ethertype_t;

    // 112 bit frame header
    typedef struct packed {
        mac_t       dest_mac;
        mac_t       src_mac;
        ethertype_t eth_type;
    } eth_hdr_t;

    // one payload byte with its sideband bits
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } eth_beat_t;

    // frame and error counter width
    localparam int stat_width = 16;

endpackage

// ==== common/eth_frame_if.sv ====
// one frame channel; a header transfer must precede the payload beats of the same frame
`timescale 1ns/1ps

interface eth_frame_if;
    import eth_pkg::*;

    // header channel
    logic      hdr_valid;
    logic      hdr_ready;
    eth_hdr_t  hdr;

    // payload channel, last marks the final byte
    logic      beat_valid;
    logic      beat_ready;
    eth_beat_t beat;

    // driven by the stage that produces the frame
    modport source (
        output hdr_valid,
        input  hdr_ready,
        output hdr,
        output beat_valid,
        input  beat_ready,
        output beat
    );

    // driven by the stage that consumes the frame
    modport sink (
        input  hdr_valid,
        output hdr_ready,
        input  hdr,
        input  beat_valid,
        output beat_ready,
        input  beat
    );

endinterface

// ==== src/eth_reg_slice.sv ====
// in_ready is registered and low for one cycle after reset; payload_t must be a packed type
`timescale 1ns/1ps

module eth_reg_slice #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    payload_t main_data;
    payload_t tmp_data;
    logic     main_valid;
    logic     tmp_valid;
    logic     tmp_valid_next;
    logic     main_load;
    logic     in_fire;

    assign in_fire   = in_valid & in_ready;
    assign main_load = ~main_valid | out_ready;
    assign out_valid = main_valid;
    assign out_data  = main_data;

    // temp register fills only when the output stalls
    always_comb begin
        tmp_valid_next = tmp_valid;
        if (main_load) begin
            tmp_valid_next = 1'b0;
        end else if (in_fire) begin
            tmp_valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            main_valid <= 1'b0;
            tmp_valid  <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            tmp_valid <= tmp_valid_next;
            in_ready  <= ~tmp_valid_next;
            if (main_load) begin
                main_valid <= tmp_valid | in_fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= tmp_valid ? tmp_data : in_data;
        end else if (in_fire) begin
            tmp_data <= in_data;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== src/eth_rx_port.sv ====
// one frame at a time; the next header is refused until the last byte of the current frame
`timescale 1ns/1ps

module eth_rx_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               hdr_valid,
    output logic               hdr_ready,
    input  eth_pkg::eth_hdr_t  hdr,
    input  logic               beat_valid,
    output logic               beat_ready,
    input  eth_pkg::eth_beat_t beat,
    eth_frame_if.source        tx
);
    import eth_pkg::*;

    logic hdr_taken;
    logic hdr_slice_ready;
    logic beat_slice_ready;

    // payload window opens on the header and closes on the last byte
    assign hdr_ready  = hdr_slice_ready & ~hdr_taken;
    assign beat_ready = beat_slice_ready & hdr_taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdr_taken <= 1'b0;
        end else if (hdr_valid && hdr_ready) begin
            hdr_taken <= 1'b1;
        end else if (beat_valid && beat_ready && beat.last) begin
            hdr_taken <= 1'b0;
        end
    end

    eth_reg_slice #(.payload_t(eth_hdr_t)) i_hdr_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (hdr_valid & ~hdr_taken),
        .in_ready  (hdr_slice_ready),
        .in_data   (hdr),
        .out_valid (tx.hdr_valid),
        .out_ready (tx.hdr_ready),
        .out_data  (tx.hdr)
    );

    eth_reg_slice #(.payload_t(eth_beat_t)) i_beat_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (beat_valid & hdr_taken),
        .in_ready  (beat_slice_ready),
        .in_data   (beat),
        .out_valid (tx.beat_valid),
        .out_ready (tx.beat_ready),
        .out_data  (tx.beat)
    );

endmodule

// ==== eth_mux/eth_mux.sv ====
// num_ports >= 2 and select must name an existing port; select is sampled only at frame start
`timescale 1ns/1ps

module eth_mux #(
    parameter int num_ports = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    eth_frame_if.sink                    rx [num_ports],
    eth_frame_if.source                  tx,
    input  logic                         enable,
    input  logic [$clog2(num_ports)-1:0] select
);
    import eth_pkg::*;

    localparam int sel_width = $clog2(num_ports);

    logic [num_ports-1:0] rx_hdr_valid;
    eth_hdr_t             rx_hdr [num_ports];
    logic [num_ports-1:0] rx_beat_valid;
    eth_beat_t            rx_beat [num_ports];
    logic [num_ports-1:0] hdr_ready_reg;
    logic [num_ports-1:0] beat_ready_reg;

    logic                 frame_reg;
    logic                 frame_next;
    logic [sel_width-1:0] sel_reg;
    logic [sel_width-1:0] sel_next;
    logic                 frame_start;

    logic                 tx_hdr_valid_reg;
    eth_hdr_t             tx_hdr_reg;

    eth_beat_t            cur_beat;
    logic                 cur_fire;

    eth_beat_t            skid_out;
    logic                 skid_out_valid;
    eth_beat_t            skid_tmp;
    logic                 skid_tmp_valid;
    logic                 skid_ready;
    logic                 skid_ready_early;

    // flatten the interface array so ports can be indexed by select
    genvar g;
    generate
        for (g = 0; g < num_ports; g++) begin : gen_rx
            assign rx_hdr_valid[g]  = rx[g].hdr_valid;
            assign rx_hdr[g]        = rx[g].hdr;
            assign rx_beat_valid[g] = rx[g].beat_valid;
            assign rx_beat[g]       = rx[g].beat;
            assign rx[g].hdr_ready  = hdr_ready_reg[g];
            assign rx[g].beat_ready = beat_ready_reg[g];
        end
    endgenerate

    assign frame_start = ~frame_reg & enable & ~tx_hdr_valid_reg & rx_hdr_valid[select];
    assign cur_beat    = rx_beat[sel_reg];
    assign cur_fire    = frame_reg & rx_beat_valid[sel_reg] & beat_ready_reg[sel_reg];

    always_comb begin
        frame_next = frame_reg;
        sel_next   = sel_reg;
        if (frame_reg) begin
            // end of frame on the accepted last byte
            if (cur_fire && cur_beat.last) begin
                frame_next = 1'b0;
            end
        end else if (frame_start) begin
            frame_next = 1'b1;
            sel_next   = select;
        end
    end

    // accept next cycle if the skid drains or still has room for one more byte
    assign skid_ready_early = tx.beat_ready |
                              (~skid_tmp_valid & (~skid_out_valid | ~cur_fire));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_reg        <= 1'b0;
            sel_reg          <= '0;
            tx_hdr_valid_reg <= 1'b0;
            hdr_ready_reg    <= '0;
            beat_ready_reg   <= '0;
        end else begin
            frame_reg        <= frame_next;
            sel_reg          <= sel_next;
            tx_hdr_valid_reg <= frame_start | (tx_hdr_valid_reg & ~tx.hdr_ready);
            for (int i = 0; i < num_ports; i++) begin
                // header ready is a one cycle pulse, the source holds valid until then
                hdr_ready_reg[i]  <= frame_start && (select == sel_width'(i));
                beat_ready_reg[i] <= skid_ready_early && frame_next &&
                                     (sel_next == sel_width'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            tx_hdr_reg <= rx_hdr[select];
        end
    end

    // two entry skid on the payload path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            skid_ready     <= 1'b0;
            skid_out_valid <= 1'b0;
            skid_tmp_valid <= 1'b0;
        end else begin
            skid_ready <= skid_ready_early;
            if (skid_ready) begin
                if (tx.beat_ready || !skid_out_valid) begin
                    skid_out_valid <= cur_fire;
                end else begin
                    skid_tmp_valid <= cur_fire;
                end
            end else if (tx.beat_ready) begin
                skid_out_valid <= skid_tmp_valid;
                skid_tmp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (skid_ready) begin
            if (tx.beat_ready || !skid_out_valid) begin
                skid_out <= cur_beat;
            end else begin
                skid_tmp <= cur_beat;
            end
        end else if (tx.beat_ready) begin
            skid_out <= skid_tmp;
        end
    end

    assign tx.hdr_valid  = tx_hdr_valid_reg;
    assign tx.hdr        = tx_hdr_reg;
    assign tx.beat_valid = skid_out_valid;
    assign tx.beat       = skid_out;

    a_one_port_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hdr_ready_reg | beat_ready_reg));

endmodule

// ==== src/eth_tx_port.sv ====
// no pipeline register; the next header waits until the last byte of the current frame is out
`timescale 1ns/1ps

module eth_tx_port (
    input  logic                           clk,
    input  logic                           rst,
    eth_frame_if.sink                      rx,
    output logic                           out_hdr_valid,
    input  logic                           out_hdr_ready,
    output eth_pkg::mac_t                  out_dest_mac,
    output eth_pkg::mac_t                  out_src_mac,
    output eth_pkg::ethertype_t            out_eth_type,
    output logic [7:0]                     out_tdata,
    output logic                           out_tvalid,
    input  logic                           out_tready,
    output logic                           out_tlast,
    output logic                           out_tuser,
    output logic [eth_pkg::stat_width-1:0] frame_count,
    output logic [eth_pkg::stat_width-1:0] err_count
);
    logic hdr_sent;
    logic last_fire;

    // header and payload take turns on the output
    assign out_hdr_valid = rx.hdr_valid & ~hdr_sent;
    assign rx.hdr_ready  = out_hdr_ready & ~hdr_sent;
    assign out_tvalid    = rx.beat_valid & hdr_sent;
    assign rx.beat_ready = out_tready & hdr_sent;

    assign out_dest_mac = rx.hdr.dest_mac;
    assign out_src_mac  = rx.hdr.src_mac;
    assign out_eth_type = rx.hdr.eth_type;
    assign out_tdata    = rx.beat.data;
    assign out_tlast    = rx.beat.last;
    assign out_tuser    = rx.beat.user;

    assign last_fire = out_tvalid & out_tready & out_tlast;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdr_sent    <= 1'b0;
            frame_count <= '0;
            err_count   <= '0;
        end else begin
            if (out_hdr_valid && out_hdr_ready) begin
                hdr_sent <= 1'b1;
            end else if (last_fire) begin
                hdr_sent <= 1'b0;
            end
            if (last_fire) begin
                frame_count <= frame_count + 1'b1;
                // user on the last byte flags a bad frame
                if (out_tuser) begin
                    err_count <= err_count + 1'b1;
                end
            end
        end
    end

    a_hdr_held: assert property (@(posedge clk) disable iff (rst)
        rx.hdr_valid && !rx.hdr_ready |=> rx.hdr_valid && $stable(rx.hdr));

endmodule

// ==== src/eth_switch_top.sv ====
// select is external and sampled per frame; no FCS check, lookup or arbitration is done here
`timescale 1ns/1ps

module eth_switch_top #(
    parameter int num_ports = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [num_ports-1:0]                  in_hdr_valid,
    output logic [num_ports-1:0]                  in_hdr_ready,
    input  eth_pkg::mac_t [num_ports-1:0]         in_dest_mac,
    input  eth_pkg::mac_t [num_ports-1:0]         in_src_mac,
    input  eth_pkg::ethertype_t [num_ports-1:0]   in_eth_type,
    input  logic [num_ports-1:0][7:0]             in_tdata,
    input  logic [num_ports-1:0]                  in_tvalid,
    output logic [num_ports-1:0]                  in_tready,
    input  logic [num_ports-1:0]                  in_tlast,
    input  logic [num_ports-1:0]                  in_tuser,
    output logic                                  out_hdr_valid,
    input  logic                                  out_hdr_ready,
    output eth_pkg::mac_t                         out_dest_mac,
    output eth_pkg::mac_t                         out_src_mac,
    output eth_pkg::ethertype_t                   out_eth_type,
    output logic [7:0]                            out_tdata,
    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output logic                                  out_tlast,
    output logic                                  out_tuser,
    input  logic                                  enable,
    input  logic [$clog2(num_ports)-1:0]          select,
    output logic [eth_pkg::stat_width-1:0]        frame_count,
    output logic [eth_pkg::stat_width-1:0]        err_count
);
    import eth_pkg::*;

    eth_frame_if port_if [num_ports] ();
    eth_frame_if mux_if ();

    genvar g;
    generate
        for (g = 0; g < num_ports; g++) begin : gen_port
            eth_hdr_t  in_hdr;
            eth_beat_t in_beat;

            // pack the flat port fields into the channel types
            assign in_hdr = '{dest_mac: in_dest_mac[g], src_mac: in_src_mac[g],
                              eth_type: in_eth_type[g]};
            assign in_beat = '{data: in_tdata[g], last: in_tlast[g], user: in_tuser[g]};

            eth_rx_port i_rx_port (
                .clk        (clk),
                .rst        (rst),
                .hdr_valid  (in_hdr_valid[g]),
                .hdr_ready  (in_hdr_ready[g]),
                .hdr        (in_hdr),
                .beat_valid (in_tvalid[g]),
                .beat_ready (in_tready[g]),
                .beat       (in_beat),
                .tx         (port_if[g])
            );
        end
    endgenerate

    eth_mux #(.num_ports(num_ports)) i_mux (
        .clk    (clk),
        .rst    (rst),
        .rx     (port_if),
        .tx     (mux_if),
        .enable (enable),
        .select (select)
    );

    eth_tx_port i_tx_port (
        .clk           (clk),
        .rst           (rst),
        .rx            (mux_if),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_dest_mac  (out_dest_mac),
        .out_src_mac   (out_src_mac),
        .out_eth_type  (out_eth_type),
        .out_tdata     (out_tdata),
        .out_tvalid    (out_tvalid),
        .out_tready    (out_tready),
        .out_tlast     (out_tlast),
        .out_tuser     (out_tuser),
        .frame_count   (frame_count),
        .err_count     (err_count)
    );

endmodule

// ==== verification/tb_eth_switch.sv ====
// frames go one at a time except the select change test; the output readies toggle at random
`timescale 1ns/1ps

module tb_eth_switch;
    localparam int num_ports = 4;
    localparam int timeout_cycles = 500;

    logic clk;
    logic rst;
    logic [num_ports-1:0] in_hdr_valid, in_hdr_ready, in_tvalid, in_tready, in_tlast, in_tuser;
    logic [num_ports-1:0][47:0] in_dest_mac, in_src_mac;
    logic [num_ports-1:0][15:0] in_eth_type;
    logic [num_ports-1:0][7:0] in_tdata;
    logic out_hdr_valid, out_hdr_ready, out_tvalid, out_tready, out_tlast, out_tuser;
    logic [47:0] out_dest_mac, out_src_mac;
    logic [15:0] out_eth_type;
    logic [7:0] out_tdata;
    logic enable;
    logic [1:0] select;
    logic [15:0] frame_count, err_count;

    // reference state, filled from the input handshakes
    logic [111:0] hdr_q [$];
    int port_q [$];
    logic [9:0] beat_q [num_ports][$];
    logic [111:0] exp_hdr, out_hdr_bus;
    logic [9:0] exp_beat, out_beat_bus;
    logic hdr_done;
    int cur_port, errors, frames_sent, bad_sent, frames_delivered, rnd, p;

    assign out_hdr_bus  = {out_dest_mac, out_src_mac, out_eth_type};
    assign out_beat_bus = {out_tdata, out_tlast, out_tuser};

    eth_switch_top #(.num_ports(num_ports)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic end_run();
        $display("frames sent %0d, delivered %0d, errors %0d", frames_sent, frames_delivered,
                 errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        end_run();
    endtask

    // returns at the rising edge where the input transfer takes place
    task automatic wait_in_ready(input int port, input bit is_hdr);
        int n;
        n = 0;
        @(posedge clk);
        while (!(is_hdr ? in_hdr_ready[port] : in_tready[port])) begin
            n++;
            if (n > timeout_cycles) give_up($sformatf("input ready on port %0d", port));
            @(posedge clk);
        end
    endtask

    task automatic send_frame(input int port, input int len, input bit bad);
        logic [5:0] base;
        base = 6'($urandom);
        frames_sent++;
        if (bad) bad_sent++;
        @(negedge clk);
        in_dest_mac[port]  = {8'h02, 8'(port), 32'($urandom)};
        in_src_mac[port]   = {8'h0a, 8'(frames_sent), 32'($urandom)};
        in_eth_type[port]  = 16'h0800 + 16'(frames_sent);
        in_hdr_valid[port] = 1'b1;
        wait_in_ready(port, 1'b1);
        @(negedge clk);
        in_hdr_valid[port] = 1'b0;
        for (int i = 0; i < len; i++) begin
            repeat ($urandom % 3) @(negedge clk);
            // upper bits of each byte carry the port number
            in_tdata[port]  = {2'(port), base + 6'(i)};
            in_tlast[port]  = (i == len - 1);
            in_tuser[port]  = bad && (i == len - 1);
            in_tvalid[port] = 1'b1;
            wait_in_ready(port, 1'b0);
            @(negedge clk);
            in_tvalid[port] = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (frames_delivered != frames_sent) begin
            n++;
            if (n > timeout_cycles) give_up("all frames to leave the output");
            @(negedge clk);
        end
    endtask

    task automatic wait_out_hdr();
        int n;
        n = 0;
        while (!out_hdr_valid) begin
            n++;
            if (n > timeout_cycles) give_up("an output header");
            @(negedge clk);
        end
    endtask

    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            a_idle: assert (!out_hdr_valid) else begin
                errors++;
                $display("output header appeared while enable was low");
            end
        end
    endtask

    // output readies change at random on every falling edge
    always @(negedge clk) begin
        if (!rst) begin
            out_hdr_ready = ($urandom % 4) != 0;
            out_tready    = ($urandom % 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_ports; i++) begin
                if (in_hdr_valid[i] && in_hdr_ready[i]) begin
                    hdr_q.push_back({in_dest_mac[i], in_src_mac[i], in_eth_type[i]});
                    port_q.push_back(i);
                end
                if (in_tvalid[i] && in_tready[i]) begin
                    beat_q[i].push_back({in_tdata[i], in_tlast[i], in_tuser[i]});
                end
            end
            if (out_hdr_valid && out_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    errors++;
                    $display("output header with no frame sent");
                end else begin
                    exp_hdr  = hdr_q.pop_front();
                    cur_port = port_q.pop_front();
                    a_hdr: assert (out_hdr_bus == exp_hdr) else begin
                        errors++;
                        $display("FAIL out_hdr exp %h got %h", exp_hdr, out_hdr_bus);
                    end
                end
                hdr_done = 1'b1;
            end
            if (out_tvalid && out_tready) begin
                if (beat_q[cur_port].size() == 0) begin
                    errors++;
                    $display("output byte with no byte sent on port %0d", cur_port);
                end else begin
                    exp_beat = beat_q[cur_port].pop_front();
                    a_beat: assert (out_beat_bus == exp_beat) else begin
                        errors++;
                        $display("FAIL out_tdata/tlast/tuser exp %h got %h", exp_beat,
                                 out_beat_bus);
                    end
                end
                if (out_tlast) begin
                    frames_delivered++;
                    hdr_done = 1'b0;
                end
            end
        end
    end

    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr_bus))
        else begin
            errors++;
            $display("FAIL out_hdr changed while stalled, now %h", out_hdr_bus);
        end

    a_beat_hold: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_beat_bus))
        else begin
            errors++;
            $display("FAIL out_tdata changed while stalled, now %h", out_beat_bus);
        end

    a_hdr_first: assert property (@(posedge clk) disable iff (rst) out_tvalid |-> hdr_done)
        else begin
            errors++;
            $display("output byte before its header transfer");
        end

    initial begin
        rnd = $urandom(26);
        in_hdr_valid = '0;
        in_dest_mac = '0;
        in_src_mac = '0;
        in_eth_type = '0;
        in_tdata = '0;
        in_tvalid = '0;
        in_tlast = '0;
        in_tuser = '0;
        out_hdr_ready = 1'b0;
        out_tready = 1'b0;
        enable = 1'b0;
        select = '0;
        hdr_done = 1'b0;
        cur_port = 0;
        errors = 0;
        frames_sent = 0;
        bad_sent = 0;
        frames_delivered = 0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        enable = 1'b1;

        // plain frames on several ports, one byte frame included
        send_frame(0, 6, 1'b0);
        wait_drain();
        select = 2'd1;
        send_frame(1, 9, 1'b1);
        wait_drain();
        select = 2'd3;
        send_frame(3, 1, 1'b0);
        wait_drain();

        // enable low holds the frame back
        enable = 1'b0;
        select = 2'd1;
        fork
            send_frame(1, 4, 1'b0);
            begin
                check_idle(30);
                enable = 1'b1;
            end
        join
        wait_drain();

        // select moves to port 2 while port 0 is still sending
        select = 2'd0;
        fork
            send_frame(0, 12, 1'b0);
            begin
                wait_out_hdr();
                select = 2'd2;
                send_frame(2, 5, 1'b1);
            end
        join
        wait_drain();

        for (int k = 0; k < 6; k++) begin
            p = $urandom % num_ports;
            @(negedge clk);
            select = 2'(p);
            send_frame(p, 1 + $urandom % 16, ($urandom % 2) == 1);
            wait_drain();
        end

        repeat (2) @(negedge clk);
        a_frames: assert (frame_count == 16'(frames_sent)) else begin
            errors++;
            $display("FAIL frame_count exp %h got %h", 16'(frames_sent), frame_count);
        end
        a_errs: assert (err_count == 16'(bad_sent)) else begin
            errors++;
            $display("FAIL err_count exp %h got %h", 16'(bad_sent), err_count);
        end
        a_empty: assert (hdr_q.size() == 0) else begin
            errors++;
            $display("headers left in the reference queue after the run");
        end
        end_run();
    end

endmodule

// ==== list.f ====
common/eth_pkg.sv
common/eth_frame_if.sv
src/eth_reg_slice.sv
src/eth_rx_port.sv
eth_mux/eth_mux.sv
src/eth_tx_port.sv
src/eth_switch_top.sv
verification/tb_eth_switch.sv
